/* source/seedPkg.sv */
// Shared types and constants for the SEED round-per-cycle core.
// Holds the widths, the controller bus, the key-schedule constants,
// the two S-box tables and the G-function masks used by every block.
package seedPkg;

	localparam int BlockWidth = 128;
	localparam int Rounds = 16;

	typedef logic [BlockWidth-1:0] block_t;
	typedef logic [BlockWidth/2-1:0] half_t; // One Feistel half or one subkey
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [Rounds-1:0] roundHot_t;

	// Controller outputs shared by both datapaths
	typedef struct packed {
		logic keyLoad;
		logic dataLoad;
		logic running;
		roundHot_t round; // Bit 0 marks round 1
		logic lastRound;
		logic decrypt;
	} ctlBus_t;

	// Key-schedule constants KC0..KC15
	localparam word_t [0:Rounds-1] KeyConst = {
		32'h9E3779B9, 32'h3C6EF373, 32'h78DDE6E6, 32'hF1BBCDCC,
		32'hE3779B99, 32'hC6EF3733, 32'h8DDE6E67, 32'h1BBCDCCF,
		32'h3779B99E, 32'h6EF3733C, 32'hDDE6E678, 32'hBBCDCCF1,
		32'h779B99E3, 32'hEF3733C6, 32'hDE6E678D, 32'hBCDCCF1B
	};

	// Byte masks m3..m0 of the G-function mix
	localparam byte_t [3:0] GMask = {8'h3F, 8'hCF, 8'hF3, 8'hFC};

	// Entry 0 sits in the leftmost byte of the first row
	localparam byte_t [0:255] SBox1 = {
		128'hA985D6D3541DAC255D43181E51FCCA63,
		128'h284420_9DE0E2C817A58F037BBB13D2EE,
		128'h708C3FA832DDF674EC950B575C5BBD01,
		128'h241C739810CCF2D92CE772839BD186C9,
		128'h6050A3EB0DB69E4FB75AC678A612AFD5,
		128'h61C3B441527D8D081F99001904_53F7E1,
		128'hFD762F27B08B0EABA26E934D697C090A,
		128'hBFEFF3C58714FE64DE2E4B1A06216B66,
		128'h02F5928A0CB37ED07A4796E52680ADDF,
		128'hA13037AE36152238F4A7454C81E98497,
		128'h35CBCE3C7111C78975FBDAF8945982C4,
		128'hFF493967C0CFD7B80F8E4223916CDBA4,
		128'h34F148C26F3D2D40BE3EBCC1AABA4E55,
		128'h3BDC687F9CD84A5677A0ED46B52B65FA,
		128'hE3B9B19F5EF9E6B231EA6D5FE4F0CD88,
		128'h163A58D462290733E81B05799_06A2A9A
	};

	localparam byte_t [0:255] SBox2 = {
		128'h38E82DA6CFDEB3B8AF6055C7446F6B5B,
		128'hC36233B529A0E2A7D39111061CBC364B,
		128'hEF886CA817C416F4C245E1D63F3D8E98,
		128'h284EF63EA5F90DDFD82B667A272FF172,
		128'h42D441C07367AC8BF7AD801FCA2CAA34,
		128'hD20BEEE95D9418F857AE08C513CD86B9,
		128'hFF7DC131F58A6AB1D120D7022204_6871,
		128'h07DB9D9961BEE659DD5190DC9AA3ABD0,
		128'h810F471AE3EC8DBF967B5CA2A163234D,
		128'hC89E9C3A0C2EBA6E9F5AF292F34978CC,
		128'h15FB70757F351003646DC674D5B4EA09,
		128'h7619FE4012E0BD05FA01F02A5EA95643,
		128'h8514899BB0E5487997FC1E82218C1B5F,
		128'h7754B21D254F004_6ED5852EB7EDAC9FD,
		128'h3095653CB6E4BB7C0E50392632846993,
		128'h37E724A4CB530A87D94C838FCE3B4AB7
	};

endpackage

/* source/seedGFunction.sv */
// SEED G function, purely combinational.
// Four S-box lookups followed by the masked byte mix.
`timescale 1ns/100ps

module seedGFunction (
	input seedPkg::word_t gIn,
	output seedPkg::word_t gOut
);

	seedPkg::byte_t sOut [4];

	// Bytes 3 and 1 use SBox2, bytes 2 and 0 use SBox1
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (i % 2 == 1)
				sOut[i] = seedPkg::SBox2[gIn[8*i +: 8]];
			else
				sOut[i] = seedPkg::SBox1[gIn[8*i +: 8]];
		end
	end

	// Output byte j takes S-box byte i through mask (i + j) mod 4
	always_comb begin
		gOut = '0;
		for (int j = 0; j < 4; j++) begin
			for (int i = 0; i < 4; i++)
				gOut[8*j +: 8] ^= sOut[i] & seedPkg::GMask[(i + j) % 4];
		end
	end

endmodule

/* source/seedControl.sv */
// FSM and one-hot round counter of the SEED core.
// Accepts key and data requests from the host while idle and drives
// the shared control bus and the BSY, Kvld and Dvld status outputs.
`timescale 1ns/100ps

module seedControl (
	input logic CLK,
	input logic RSTn,
	input logic Krdy,
	input logic Drdy,
	input logic EncDec, // High selects decryption
	output seedPkg::ctlBus_t ctl,
	output logic BSY,
	output logic Kvld,
	output logic Dvld
);

	typedef enum logic [2:0] {
		StInitial,  // No key loaded yet
		StIdle,
		StKeySched,
		StEncrypt,
		StDecrypt
	} state_t;

	state_t state;
	seedPkg::roundHot_t round;
	logic ready;
	logic running;
	logic keyLoad;
	logic dataLoad;

	assign ready = (state == StInitial) || (state == StIdle);
	assign running = (state == StEncrypt) || (state == StDecrypt);

	// Krdy wins over Drdy, data waits for a key
	assign keyLoad = ready && Krdy;
	assign dataLoad = (state == StIdle) && !Krdy && Drdy;

	always_comb begin
		ctl.keyLoad = keyLoad;
		ctl.dataLoad = dataLoad;
		ctl.running = running;
		ctl.round = round;
		ctl.lastRound = running && round[seedPkg::Rounds-1];
		ctl.decrypt = running ? (state == StDecrypt) : EncDec; // Live while accepting
	end

	assign BSY = !ready;
	assign Kvld = (state == StKeySched);
	assign Dvld = running && round[seedPkg::Rounds-1];

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			state <= StInitial;
			round <= seedPkg::roundHot_t'(1);
		end else begin
			case (state)
				StInitial, StIdle: begin
					if (keyLoad)
						state <= StKeySched;
					else if (dataLoad)
						state <= EncDec ? StDecrypt : StEncrypt;
				end
				StKeySched: state <= StIdle;
				StEncrypt, StDecrypt: begin
					round <= {round[seedPkg::Rounds-2:0], round[seedPkg::Rounds-1]};
					if (round[seedPkg::Rounds-1])
						state <= StIdle; // Marker wraps back to bit 0
				end
				default: state <= StInitial;
			endcase
		end
	end

endmodule

/* source/seedKeySchedule.sv */
// SEED key schedule for the one-round-per-cycle core.
// Keeps the 128-bit key, rotates its halves round by round and
// registers the 64-bit subkey that the round datapath uses next cycle.
`timescale 1ns/100ps

module seedKeySchedule (
	input logic CLK,
	input logic RSTn,
	input seedPkg::block_t Kin,
	input seedPkg::ctlBus_t ctl,
	output seedPkg::half_t subkey
);

	// Rounds 1, 3, ... 15 rotate the lower half
	localparam seedPkg::roundHot_t OddRounds = 16'h5555;

	seedPkg::half_t keyHi;
	seedPkg::half_t keyLo;
	seedPkg::roundHot_t constHot;
	seedPkg::word_t roundConst;
	seedPkg::word_t g1In;
	seedPkg::word_t g1Out;
	seedPkg::word_t g2In;
	seedPkg::word_t g2Out;
	logic oddRound;

	function automatic seedPkg::half_t rotR8(input seedPkg::half_t h);
		return {h[7:0], h[63:8]};
	endfunction

	function automatic seedPkg::half_t rotL8(input seedPkg::half_t h);
		return {h[55:0], h[63:56]};
	endfunction

	// Constant index runs one ahead of the round marker
	assign constHot = ctl.running ?
		{ctl.round[seedPkg::Rounds-2:0], ctl.round[seedPkg::Rounds-1]} :
		seedPkg::roundHot_t'(1);

	always_comb begin
		roundConst = '0;
		for (int i = 0; i < seedPkg::Rounds; i++) begin
			if (constHot[i])
				roundConst |= ctl.decrypt ? seedPkg::KeyConst[seedPkg::Rounds-1-i] :
					seedPkg::KeyConst[i]; // Reversed order for decryption
		end
	end

	assign g1In = (keyHi[63:32] + keyLo[63:32]) - roundConst;
	assign g2In = (keyHi[31:0] - keyLo[31:0]) + roundConst;

	seedGFunction gKey1 (.gIn(g1In), .gOut(g1Out));
	seedGFunction gKey2 (.gIn(g2In), .gOut(g2Out));

	assign oddRound = |(ctl.round & OddRounds);

	always_ff @(posedge CLK) begin
		if (!RSTn) begin
			keyHi <= '0;
			keyLo <= '0;
		end else if (ctl.keyLoad) begin
			keyHi <= Kin[127:64];
			keyLo <= ctl.decrypt ? rotR8(Kin[63:0]) : Kin[63:0];
		end else if (ctl.dataLoad) begin
			keyHi <= ctl.decrypt ? rotL8(keyHi) : rotR8(keyHi); // First upper rotation
		end else if (ctl.running && !ctl.lastRound) begin
			if (oddRound)
				keyLo <= ctl.decrypt ? rotR8(keyLo) : rotL8(keyLo);
			else
				keyHi <= ctl.decrypt ? rotL8(keyHi) : rotR8(keyHi);
		end
	end

	// Subkey for the next round, one cycle behind the key
	always_ff @(posedge CLK) begin
		if (!RSTn)
			subkey <= '0;
		else
			subkey <= {g1Out, g2Out};
	end

endmodule

/* source/seedRound.sv */
// SEED round datapath with the Feistel F function.
// Loads a block on dataLoad and applies one round per running cycle.
// Dout is the swapped next state, the result during the last round.
`timescale 1ns/100ps

module seedRound (
	input logic CLK,
	input logic RSTn,
	input seedPkg::block_t Din,
	input seedPkg::half_t subkey,
	input seedPkg::ctlBus_t ctl,
	output seedPkg::block_t Dout
);

	seedPkg::block_t dataReg;
	seedPkg::block_t dataNext;
	seedPkg::half_t keyed;
	seedPkg::half_t fOut;
	seedPkg::word_t g1In;
	seedPkg::word_t g1Out;
	seedPkg::word_t g2In;
	seedPkg::word_t g2Out;
	seedPkg::word_t g3In;
	seedPkg::word_t g3Out;

	assign keyed = dataReg[63:0] ^ subkey; // Right half mixed with subkey

	// Three-G chain with modular adds
	assign g1In = keyed[31:0] ^ keyed[63:32];
	assign g2In = g1Out + keyed[63:32];
	assign g3In = g1Out + g2Out;

	seedGFunction gF1 (.gIn(g1In), .gOut(g1Out));
	seedGFunction gF2 (.gIn(g2In), .gOut(g2Out));
	seedGFunction gF3 (.gIn(g3In), .gOut(g3Out));

	assign fOut = {g2Out + g3Out, g3Out};
	assign dataNext = {dataReg[63:0], dataReg[127:64] ^ fOut};
	assign Dout = {dataNext[63:0], dataNext[127:64]};

	always_ff @(posedge CLK) begin
		if (!RSTn)
			dataReg <= '0;
		else if (ctl.dataLoad)
			dataReg <= Din;
		else if (ctl.running)
			dataReg <= dataNext;
	end

endmodule

/* source/seedTop.sv */
// Top level of the SEED core, one round per clock.
// The host loads a key with Krdy, then requests blocks with Drdy while
// BSY is low. The result is valid on Dout only while Dvld is high.
`timescale 1ns/100ps

module seedTop (
	input logic CLK,
	input logic RSTn,
	input seedPkg::block_t Kin,
	input seedPkg::block_t Din,
	input logic Krdy,
	input logic Drdy,
	input logic EncDec,
	output seedPkg::block_t Dout,
	output logic BSY,
	output logic Kvld,
	output logic Dvld
);

	seedPkg::ctlBus_t ctl;
	seedPkg::half_t subkey;

	seedControl control (
		.CLK(CLK),
		.RSTn(RSTn),
		.Krdy(Krdy),
		.Drdy(Drdy),
		.EncDec(EncDec),
		.ctl(ctl),
		.BSY(BSY),
		.Kvld(Kvld),
		.Dvld(Dvld)
	);

	seedKeySchedule keySchedule (
		.CLK(CLK),
		.RSTn(RSTn),
		.Kin(Kin),
		.ctl(ctl),
		.subkey(subkey)
	);

	seedRound round (
		.CLK(CLK),
		.RSTn(RSTn),
		.Din(Din),
		.subkey(subkey),
		.ctl(ctl),
		.Dout(Dout)
	);

endmodule

/* dv/seedTb.sv */
// Self-checking testbench for the SEED core.
// Runs the published vectors in both directions, checks the handshake
// timing on every key load and block, then random round trips.
`timescale 1ns/100ps

module seedTb;

	typedef struct packed {
		seedPkg::block_t key;
		seedPkg::block_t plain;
		seedPkg::block_t cipher;
	} vector_t;

	localparam int NumVectors = 3;
	localparam int WaitLimit = 40; // Cycles per wait loop
	localparam int RoundTrips = 4;

	// Published SEED known-answer rows of key, plaintext and ciphertext
	localparam vector_t [0:NumVectors-1] Vectors = {
		{128'h00000000000000000000000000000000,
			128'h000102030405060708090A0B0C0D0E0F,
			128'h5EBAC6E0054E166819AFF1CC6D346CDB},
		{128'h000102030405060708090A0B0C0D0E0F,
			128'h00000000000000000000000000000000,
			128'hC11F22F20140505084483597E4370F43},
		{128'h4706480851E61BE85D74BFB3FD956185,
			128'h83A2F8A288641FB9A4E9A5CC2F131C7D,
			128'hEE54D13EBCAE706D226BC3142CD40D4A}
	};

	logic CLK;
	logic RSTn;
	logic Krdy;
	logic Drdy;
	logic EncDec;
	seedPkg::block_t Kin;
	seedPkg::block_t Din;
	seedPkg::block_t Dout;
	logic BSY;
	logic Kvld;
	logic Dvld;

	int errors;
	int testErrors; // Error count when the current test started
	int tests;
	int failedTests;
	bit timedOut;

	seedTop UUT (.*);

	always #10 CLK = ~CLK;

	task automatic compare(input string name, input seedPkg::block_t got,
		input seedPkg::block_t expected);
		if (got !== expected) begin
			$display("CHECK FAILED %s: got %0h, expected %0h", name, got, expected);
			errors++;
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timeout: %s", what);
		errors++;
		timedOut = 1'b1;
	endtask

	// Starts and ends on a falling edge
	task automatic waitIdle();
		int n;
		n = 0;
		while (BSY !== 1'b0 && n < WaitLimit) begin
			@(negedge CLK);
			n++;
		end
		if (BSY !== 1'b0)
			reportTimeout("BSY did not go low before a request");
	endtask

	task automatic loadKey(input seedPkg::block_t key, input logic decrypt);
		if (timedOut)
			return;
		waitIdle();
		if (timedOut)
			return;
		@(posedge CLK);
		Kin <= key;
		EncDec <= decrypt;
		Krdy <= 1'b1;
		@(negedge CLK);
		compare("Kvld", Kvld, 0); // Request not yet accepted
		@(posedge CLK); // Krdy accepted here
		Krdy <= 1'b0;
		@(negedge CLK);
		compare("Kvld", Kvld, 1);
		compare("BSY", BSY, 1);
		@(negedge CLK);
		compare("Kvld", Kvld, 0);
		compare("BSY", BSY, 0);
	endtask

	task automatic runBlock(input seedPkg::block_t block, input logic decrypt,
		output seedPkg::block_t result);
		int cycles;
		result = 'x;
		if (timedOut)
			return;
		waitIdle();
		if (timedOut)
			return;
		@(posedge CLK);
		Din <= block;
		EncDec <= decrypt; // Same direction as the key load
		Drdy <= 1'b1;
		@(posedge CLK); // Drdy accepted and round 1 starts
		Drdy <= 1'b0;
		cycles = 0;
		do begin
			@(negedge CLK);
			cycles++;
			compare("BSY", BSY, 1);
		end while (Dvld !== 1'b1 && cycles < WaitLimit);
		if (Dvld !== 1'b1) begin
			reportTimeout("Dvld never rose after a data request");
			return;
		end
		compare("Dvld latency", cycles, seedPkg::Rounds);
		result = Dout;
		@(negedge CLK);
		compare("Dvld", Dvld, 0);
		compare("BSY", BSY, 0);
	endtask

	task automatic endTest(input string name);
		tests++;
		if (errors == testErrors) begin
			$display("PASS  %s", name);
		end else begin
			failedTests++;
			$display("FAIL  %s (%0d errors)", name, errors - testErrors);
		end
		testErrors = errors;
	endtask

	function automatic seedPkg::block_t randomBlock();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	initial begin
		seedPkg::block_t result;
		seedPkg::block_t key;
		seedPkg::block_t plain;
		void'($urandom(32'h573a));
		CLK = 1'b0;
		RSTn = 1'b0;
		Krdy = 1'b0;
		Drdy = 1'b0;
		EncDec = 1'b0;
		Kin = '0;
		Din = '0;
		errors = 0;
		testErrors = 0;
		tests = 0;
		failedTests = 0;
		timedOut = 1'b0;
		repeat (8) @(posedge CLK);
		RSTn <= 1'b1;
		@(negedge CLK);

		compare("BSY", BSY, 0);
		compare("Kvld", Kvld, 0);
		compare("Dvld", Dvld, 0);
		@(posedge CLK);
		Drdy <= 1'b1; // Ignored without a key
		@(posedge CLK);
		Drdy <= 1'b0;
		repeat (20) begin
			@(negedge CLK);
			compare("BSY", BSY, 0);
			compare("Dvld", Dvld, 0);
		end
		endTest("reset state and Drdy before key");

		for (int i = 0; i < NumVectors; i++) begin
			loadKey(Vectors[i].key, 1'b0);
			runBlock(Vectors[i].plain, 1'b0, result);
			compare("Dout", result, Vectors[i].cipher);
			endTest($sformatf("encrypt vector %0d", i));
		end

		for (int i = 0; i < NumVectors; i++) begin
			loadKey(Vectors[i].key, 1'b1);
			runBlock(Vectors[i].cipher, 1'b1, result);
			compare("Dout", result, Vectors[i].plain);
			endTest($sformatf("decrypt vector %0d", i));
		end

		for (int i = 0; i < RoundTrips; i++) begin
			key = randomBlock();
			plain = randomBlock();
			loadKey(key, 1'b0);
			runBlock(plain, 1'b0, result);
			loadKey(key, 1'b1); // Reload for the other direction
			runBlock(result, 1'b1, result);
			compare("Dout", result, plain);
			endTest($sformatf("random round trip %0d", i));
		end

		// Key register must be restored after every block
		loadKey(Vectors[2].key, 1'b0);
		for (int i = 0; i < 3; i++) begin
			runBlock(Vectors[2].plain, 1'b0, result);
			compare("Dout", result, Vectors[2].cipher);
		end
		loadKey(Vectors[2].key, 1'b1);
		for (int i = 0; i < 3; i++) begin
			runBlock(Vectors[2].cipher, 1'b1, result);
			compare("Dout", result, Vectors[2].plain);
		end
		endTest("repeated blocks under one key load");

		$display("Tests %0d, failed %0d, errors %0d", tests, failedTests, errors);
		if (errors == 0 && !timedOut)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* all.f */
source/seedPkg.sv
source/seedGFunction.sv
source/seedControl.sv
source/seedKeySchedule.sv
source/seedRound.sv
source/seedTop.sv
dv/seedTb.sv

/* run.sh */
#!/bin/sh
# Builds the SEED testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module seedTb -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VseedTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
